/* Makefile */
VERILATOR ?= verilator
TOP       := fetch_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* sources.f */
verilog/fetch_pkg.sv
verilog/fetch_if.sv
verilog/instr_cache.sv
verilog/fetch_sequencer.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
tb/fetch_clock.sv
tb/fetch_tb.sv

/* tb/fetch_clock.sv */
`timescale 1ns/1ps

module fetch_clock (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #10 o_clock = ~o_clock;
	end

	// Reset held for three rising edges, dropped after the third one
	initial begin
		o_reset = 1'b1;
		repeat (3) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

/* tb/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

	localparam addr_t IRQ_PC = 32'h0000_1000;
	localparam int PROG_WORDS = 64;
	localparam int TOTAL_STEPS = 510;
	localparam int TIMEOUT_CYCLES = 200 * TOTAL_STEPS;
	localparam int MODE_FETCH = 0;
	localparam int MODE_JUMP = 1;
	localparam int MODE_IRQ = 2;

	logic clock;
	logic reset;
	logic i_jump = 1'b0;
	addr_t i_jump_pc = '0;
	logic i_irq_pending = 1'b0;
	addr_t i_irq_pc = '0;
	logic i_bus_ready = 1'b0;
	instr_t i_bus_rdata = '0;
	logic i_decode_credit = 1'b0;
	logic o_irq_dispatched;
	addr_t o_irq_epc;
	logic o_bus_request;
	addr_t o_bus_address;
	logic o_fetch_valid;
	addr_t o_fetch_pc;
	instr_t o_fetch_instr;
	tag_t o_fetch_tag;

	logic [31:0] rng_state = 32'h0a2c_838d;
	instr_t prog [PROG_WORDS];
	instr_t handler [8];
	bit model_valid [CACHE_LINES];
	logic [25:0] model_tag [CACHE_LINES];

	// Reference model state
	int mode = MODE_FETCH;
	addr_t exp_pc = RESET_VECTOR;
	tag_t exp_tag = '0;
	addr_t jump_target = '0;
	addr_t ret_pc = '0;
	int jump_wait = 0;
	bit in_handler = 0;
	bit irq_active = 0;
	bit irq_seen = 0;
	bit async_req = 0;
	bit withhold = 0;
	bit bus_busy = 0;
	int bus_wait = 0;
	int delivered = 0;
	int returned = 0;
	int pending_credits = 0;
	int cycles = 0;
	int errors = 0;
	int trap_count = 0;
	int irq_count = 0;

	fetch_clock u_clock (.o_clock(clock), .o_reset(reset));

	fetch_top dut (
		.i_clock(clock), .i_reset(reset),
		.i_jump(i_jump), .i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending), .i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched), .o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request), .o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata),
		.o_fetch_valid(o_fetch_valid), .o_fetch_pc(o_fetch_pc),
		.o_fetch_instr(o_fetch_instr), .o_fetch_tag(o_fetch_tag),
		.i_decode_credit(i_decode_credit)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Program at the reset vector, handler at IRQ_PC, ALU fill elsewhere
	function automatic instr_t mem_word(input addr_t a);
		if (a < 32'h0000_0100) return prog[a[7:2]];
		if (a >= IRQ_PC && a < IRQ_PC + 32'h20) return handler[a[4:2]];
		return {a[24:0] ^ a[31:7], 7'b0010011};
	endfunction

	task automatic fill_program();
		logic [31:0] r;
		for (int i = 0; i < PROG_WORDS; i++) begin
			r = next_random();
			case (r[3:0])
				4'd10: prog[i] = {r[31:7], OPC_JAL};
				4'd11: prog[i] = {r[31:7], OPC_BRANCH};
				4'd12: prog[i] = INSTR_ECALL;
				4'd13: prog[i] = INSTR_WFI;
				4'd14: prog[i] = INSTR_MRET;
				default: prog[i] = {r[31:7], 7'b0010011};
			endcase
		end
		// Keeps straight-line runs inside program memory
		prog[PROG_WORDS-1] = {25'h0, OPC_JAL};
		for (int i = 0; i < 7; i++) begin
			r = next_random();
			handler[i] = {r[31:7], 7'b0110011};
		end
		handler[7] = INSTR_MRET;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		errors++;
		$display("ERR %s expected %h got %h", name, exp, got);
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("Failure: %s", what);
	endtask

	task automatic serve_bus();
		logic [31:0] r;
		addr_t a;
		line_index_t idx;
		a = o_bus_address;
		idx = a[5:2];
		if (i_bus_ready) begin
			i_bus_ready = 1'b0;
			bus_busy = 0;
		end else if (o_bus_request) begin
			if (!bus_busy) begin
				r = next_random();
				bus_busy = 1;
				bus_wait = int'(r[1:0]);
				if (model_valid[idx] && model_tag[idx] == a[31:6]) begin
					note_failure($sformatf("bus request for %h which is still cached", a));
				end
				model_valid[idx] = 1;
				model_tag[idx] = a[31:6];
			end
			if (bus_wait == 0) begin
				i_bus_ready = 1'b1;
				i_bus_rdata = mem_word(a);
			end else begin
				bus_wait--;
			end
		end
	endtask

	task automatic watch_irq();
		if (irq_active && !irq_seen && o_irq_dispatched) begin
			irq_seen = 1;
			i_irq_pending = 1'b0;
		end else if (!irq_active && !in_handler && !o_irq_dispatched &&
			(mode == MODE_IRQ || (async_req && mode == MODE_FETCH))) begin
			i_irq_pending = 1'b1;
			i_irq_pc = IRQ_PC;
			irq_active = 1;
			irq_seen = 0;
			if (mode == MODE_FETCH) async_req = 0;
		end
	endtask

	task automatic check_entry();
		logic [31:0] r;
		logic [6:0] opc;
		instr_t exp_word;
		delivered++;
		pending_credits++;
		// First handler entry closes the interrupt
		if (irq_active && o_fetch_pc >= IRQ_PC) begin
			if (!irq_seen) note_failure("handler entry arrived before o_irq_dispatched rose");
			if (o_irq_epc != exp_pc) report_mismatch("o_irq_epc", exp_pc, o_irq_epc);
			ret_pc = exp_pc;
			exp_pc = IRQ_PC;
			mode = MODE_FETCH;
			irq_active = 0;
			in_handler = 1;
			irq_count++;
		end else if (mode != MODE_FETCH) begin
			note_failure($sformatf("entry at %h arrived while fetch should wait", o_fetch_pc));
		end
		exp_word = mem_word(exp_pc);
		if (o_fetch_pc != exp_pc) report_mismatch("o_fetch_pc", exp_pc, o_fetch_pc);
		if (o_fetch_instr != exp_word) begin
			report_mismatch("o_fetch_instr", exp_word, o_fetch_instr);
		end
		if (o_fetch_tag != exp_tag) report_mismatch("o_fetch_tag", 32'(exp_tag), 32'(o_fetch_tag));
		exp_tag = exp_tag + 8'd1;
		exp_pc = exp_pc + 32'd4;
		opc = exp_word[6:0];
		if (opc == OPC_JAL || opc == OPC_JALR || opc == OPC_BRANCH ||
			exp_word == INSTR_MRET) begin
			r = next_random();
			mode = MODE_JUMP;
			jump_wait = 1 + int'(r[9:8]);
			jump_target = in_handler ? ret_pc : {24'h0, r[5:0], 2'b00};
		end else if (exp_word == INSTR_ECALL || exp_word == INSTR_WFI) begin
			mode = MODE_IRQ;
			trap_count++;
		end
	endtask

	task automatic drive_credit_and_jump();
		logic [31:0] r;
		r = next_random();
		i_decode_credit = 1'b0;
		if (!withhold && pending_credits > 0 && r[2:0] != 3'd0) begin
			i_decode_credit = 1'b1;
			pending_credits--;
			returned++;
		end
		i_jump = 1'b0;
		if (mode == MODE_JUMP) begin
			if (jump_wait > 0) begin
				jump_wait--;
			end else begin
				i_jump = 1'b1;
				i_jump_pc = jump_target;
				exp_pc = jump_target;
				mode = MODE_FETCH;
				in_handler = 0;
			end
		end
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("Timeout after %0d cycles with %0d entries delivered", cycles, delivered);
				$display("TEST RESULT: FAIL");
				$finish;
			end else begin
				serve_bus();
				watch_irq();
				if (o_fetch_valid) check_entry();
				if (delivered > DECODE_CREDITS + returned) begin
					note_failure("more entries delivered than decode credits allow");
				end
				drive_credit_and_jump();
			end
		end
	end

	task automatic run_test(input string name, input int entries);
		int start_errors;
		int target;
		start_errors = errors;
		target = delivered + entries;
		while (delivered < target) @(posedge clock);
		$display("%s: %0d entries, %0d errors", name, entries, errors - start_errors);
	endtask

	initial begin
		int irq_before;
		int held;
		fill_program();
		@(negedge clock);
		if (o_bus_request || o_fetch_valid || o_irq_dispatched) begin
			note_failure("bus request, fetch valid or irq dispatch high during reset");
		end
		while (reset) @(posedge clock);
		run_test("sequential_fetch_and_jumps", 150);

		irq_before = irq_count;
		async_req = 1;
		run_test("async_interrupt", 60);
		if (async_req || irq_count == irq_before) begin
			note_failure("asynchronous interrupt never reached the handler");
		end

		withhold = 1;
		held = delivered;
		repeat (40) @(posedge clock);
		if (delivered - held > DECODE_CREDITS) note_failure("queue ignored withheld credits");
		withhold = 0;
		run_test("credit_backpressure", 60);

		run_test("cache_reuse", 200);

		$display("Totals: %0d entries, %0d traps, %0d interrupts, %0d errors",
			delivered, trap_count, irq_count, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* verilog/fetch_if.sv */
`timescale 1ns/1ps

interface fetch_if import fetch_pkg::*; ();

	// One-cycle push, only issued while the sequencer holds a credit
	logic valid;
	addr_t pc;
	instr_t instr;
	tag_t tag;

	// One-cycle pulse per entry popped from the queue
	logic credit;

	modport producer (
		output valid,
		output pc,
		output instr,
		output tag,
		input credit
	);

	modport consumer (
		input valid,
		input pc,
		input instr,
		input tag,
		output credit
	);

endinterface

/* verilog/fetch_pkg.sv */
package fetch_pkg;

	localparam int ADDR_W = 32;
	localparam int INSTR_W = 32;
	localparam int TAG_W = 8;

	localparam logic [ADDR_W-1:0] RESET_VECTOR = 32'h0000_0000;

	// Direct-mapped cache with one word per line
	localparam int CACHE_INDEX_W = 4;
	localparam int CACHE_LINES = 1 << CACHE_INDEX_W;
	localparam int CACHE_TAG_W = ADDR_W - CACHE_INDEX_W - 2;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int DECODE_CREDITS = 2;
	localparam int DECODE_CNT_W = $clog2(DECODE_CREDITS + 1);

	// RV32I major opcodes and fixed system words
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
	localparam logic [INSTR_W-1:0] INSTR_ECALL = 32'h0000_0073;
	localparam logic [INSTR_W-1:0] INSTR_WFI = 32'h1050_0073;
	localparam logic [INSTR_W-1:0] INSTR_MRET = 32'h3020_0073;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [CACHE_INDEX_W-1:0] line_index_t;
	typedef logic [CACHE_TAG_W-1:0] line_tag_t;
	typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
	typedef logic [QUEUE_CNT_W-1:0] queue_cnt_t;
	typedef logic [DECODE_CNT_W-1:0] decode_cnt_t;

	typedef enum logic [1:0] {
		SEQ_FETCH,
		SEQ_WAIT_JUMP,
		SEQ_WAIT_IRQ
	} seq_state_t;

endpackage

/* verilog/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	fetch_if.consumer fetch,

	output logic o_fetch_valid,
	output addr_t o_fetch_pc,
	output instr_t o_fetch_instr,
	output tag_t o_fetch_tag,
	input logic i_decode_credit
);

	addr_t pc_mem [QUEUE_DEPTH];
	instr_t instr_mem [QUEUE_DEPTH];
	tag_t tag_mem [QUEUE_DEPTH];

	queue_ptr_t wr_ptr;
	queue_ptr_t rd_ptr;
	queue_cnt_t count;
	decode_cnt_t decode_credits;

	logic fifo_empty;
	logic pop;

	assign fifo_empty = (count == '0);
	// An empty FIFO passes the incoming push straight through
	assign pop = (!fifo_empty || fetch.valid) && (decode_credits != '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			decode_credits <= decode_cnt_t'(DECODE_CREDITS);
			o_fetch_valid <= 1'b0;
			fetch.credit <= 1'b0;
		end else begin
			if (fetch.valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + queue_cnt_t'(fetch.valid) - queue_cnt_t'(pop);
			decode_credits <= decode_credits - decode_cnt_t'(pop) +
				decode_cnt_t'(i_decode_credit);
			o_fetch_valid <= pop;
			fetch.credit <= pop;
		end
	end

	always_ff @(posedge i_clock) begin
		if (fetch.valid) begin
			pc_mem[wr_ptr] <= fetch.pc;
			instr_mem[wr_ptr] <= fetch.instr;
			tag_mem[wr_ptr] <= fetch.tag;
		end
		if (pop) begin
			o_fetch_pc <= fifo_empty ? fetch.pc : pc_mem[rd_ptr];
			o_fetch_instr <= fifo_empty ? fetch.instr : instr_mem[rd_ptr];
			o_fetch_tag <= fifo_empty ? fetch.tag : tag_mem[rd_ptr];
		end
	end

	a_push_not_full: assert property (
		@(posedge i_clock) disable iff (i_reset)
		fetch.valid |-> (count < QUEUE_DEPTH)
	) else $error("push into a full fetch queue");

	a_decode_credit_bound: assert property (
		@(posedge i_clock) disable iff (i_reset)
		decode_credits <= DECODE_CREDITS
	) else $error("decode credits above DECODE_CREDITS");

endmodule

/* verilog/fetch_sequencer.sv */
`timescale 1ns/1ps

module fetch_sequencer import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input logic i_jump,
	input addr_t i_jump_pc,

	input logic i_irq_pending,
	input addr_t i_irq_pc,
	output logic o_irq_dispatched,
	output addr_t o_irq_epc,

	output addr_t o_pc,
	output logic o_stall,
	input instr_t i_instr,
	input logic i_ready,

	fetch_if.producer fetch
);

	seq_state_t state;
	addr_t pc_q;
	tag_t tag_q;
	queue_cnt_t credits;

	logic [6:0] opcode;
	logic is_system;
	logic is_control;
	logic is_trap;
	logic irq_take;
	logic push;

	// Pre-decode of the word at the current pc
	assign opcode = i_instr[6:0];
	assign is_system = (opcode == OPC_SYSTEM);
	assign is_control = (opcode == OPC_JAL) || (opcode == OPC_JALR) ||
		(opcode == OPC_BRANCH) || (is_system && i_instr == INSTR_MRET);
	assign is_trap = is_system && ((i_instr == INSTR_ECALL) || (i_instr == INSTR_WFI));

	assign irq_take = i_irq_pending && !o_irq_dispatched &&
		((state == SEQ_FETCH) || (state == SEQ_WAIT_IRQ));
	assign push = (state == SEQ_FETCH) && !irq_take && i_ready && (credits != '0);

	assign o_pc = pc_q;
	assign o_stall = (state != SEQ_FETCH) || (credits == '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= SEQ_FETCH;
			pc_q <= RESET_VECTOR;
			tag_q <= '0;
			credits <= queue_cnt_t'(QUEUE_DEPTH);
			fetch.valid <= 1'b0;
			o_irq_dispatched <= 1'b0;
		end else begin
			fetch.valid <= push;
			credits <= credits - queue_cnt_t'(push) + queue_cnt_t'(fetch.credit);
			if (push) begin
				tag_q <= tag_q + 1'b1;
			end

			if (irq_take) begin
				o_irq_dispatched <= 1'b1;
			end else if (!i_irq_pending) begin
				o_irq_dispatched <= 1'b0;
			end

			case (state)
				SEQ_FETCH: begin
					if (irq_take) begin
						pc_q <= i_irq_pc;
					end else if (push) begin
						if (is_control) begin
							state <= SEQ_WAIT_JUMP;
						end else if (is_trap) begin
							state <= SEQ_WAIT_IRQ;
						end else begin
							pc_q <= pc_q + 32'd4;
						end
					end
				end
				SEQ_WAIT_JUMP: begin
					if (i_jump) begin
						pc_q <= i_jump_pc;
						state <= SEQ_FETCH;
					end
				end
				SEQ_WAIT_IRQ: begin
					if (irq_take) begin
						pc_q <= i_irq_pc;
						state <= SEQ_FETCH;
					end
				end
				default: state <= SEQ_FETCH;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (push) begin
			fetch.pc <= pc_q;
			fetch.instr <= i_instr;
			fetch.tag <= tag_q;
		end
		// Return past the trapping instruction, or to the word not yet fetched
		if (irq_take) begin
			o_irq_epc <= (state == SEQ_WAIT_IRQ) ? pc_q + 32'd4 : pc_q;
		end
	end

	a_queue_credit_bound: assert property (
		@(posedge i_clock) disable iff (i_reset)
		credits <= QUEUE_DEPTH
	) else $error("queue credits above QUEUE_DEPTH");

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input logic i_jump,
	input addr_t i_jump_pc,

	input logic i_irq_pending,
	input addr_t i_irq_pc,
	output logic o_irq_dispatched,
	output addr_t o_irq_epc,

	output logic o_bus_request,
	output addr_t o_bus_address,
	input logic i_bus_ready,
	input instr_t i_bus_rdata,

	output logic o_fetch_valid,
	output addr_t o_fetch_pc,
	output instr_t o_fetch_instr,
	output tag_t o_fetch_tag,
	input logic i_decode_credit
);

	addr_t cache_pc;
	logic cache_stall;
	instr_t cache_instr;
	logic cache_ready;

	fetch_if fetch_bus ();

	instr_cache u_cache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(cache_pc),
		.i_stall(cache_stall),
		.o_instr(cache_instr),
		.o_ready(cache_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	fetch_sequencer u_sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_pc(cache_pc),
		.o_stall(cache_stall),
		.i_instr(cache_instr),
		.i_ready(cache_ready),
		.fetch(fetch_bus.producer)
	);

	fetch_queue u_queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.fetch(fetch_bus.consumer),
		.o_fetch_valid(o_fetch_valid),
		.o_fetch_pc(o_fetch_pc),
		.o_fetch_instr(o_fetch_instr),
		.o_fetch_tag(o_fetch_tag),
		.i_decode_credit(i_decode_credit)
	);

endmodule

/* verilog/instr_cache.sv */
`timescale 1ns/1ps

module instr_cache import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input addr_t i_pc,
	input logic i_stall,
	output instr_t o_instr,
	output logic o_ready,

	output logic o_bus_request,
	output addr_t o_bus_address,
	input logic i_bus_ready,
	input instr_t i_bus_rdata
);

	typedef enum logic {
		CACHE_LOOKUP,
		CACHE_REFILL
	} cache_state_t;

	cache_state_t state;

	instr_t line_data [CACHE_LINES];
	line_tag_t line_tag [CACHE_LINES];
	logic [CACHE_LINES-1:0] line_valid;

	// Address that the registered result belongs to
	addr_t resp_pc;
	logic resp_valid;

	line_index_t lookup_index;
	line_tag_t lookup_tag;
	line_index_t fill_index;
	line_tag_t fill_tag;
	logic lookup_hit;

	assign lookup_index = i_pc[CACHE_INDEX_W+1:2];
	assign lookup_tag = i_pc[ADDR_W-1:CACHE_INDEX_W+2];
	assign fill_index = o_bus_address[CACHE_INDEX_W+1:2];
	assign fill_tag = o_bus_address[ADDR_W-1:CACHE_INDEX_W+2];
	assign lookup_hit = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);

	// A result for an older pc never counts as ready
	assign o_ready = resp_valid && (resp_pc == i_pc);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CACHE_LOOKUP;
			line_valid <= '0;
			resp_valid <= 1'b0;
			o_bus_request <= 1'b0;
		end else begin
			case (state)
				CACHE_LOOKUP: begin
					if (!i_stall) begin
						resp_valid <= lookup_hit;
						if (!lookup_hit) begin
							o_bus_request <= 1'b1;
							state <= CACHE_REFILL;
						end
					end
				end
				CACHE_REFILL: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						line_valid[fill_index] <= 1'b1;
						resp_valid <= 1'b1;
						state <= CACHE_LOOKUP;
					end
				end
				default: state <= CACHE_LOOKUP;
			endcase
		end
	end

	// Line storage and result word
	always_ff @(posedge i_clock) begin
		if (state == CACHE_LOOKUP && !i_stall) begin
			o_instr <= line_data[lookup_index];
			resp_pc <= i_pc;
			o_bus_address <= i_pc;
		end
		if (state == CACHE_REFILL && i_bus_ready) begin
			line_data[fill_index] <= i_bus_rdata;
			line_tag[fill_index] <= fill_tag;
			o_instr <= i_bus_rdata;
			resp_pc <= o_bus_address;
		end
	end

	a_bus_address_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_address))
	) else $error("bus request dropped or address changed before ready");

endmodule
